// ==== design/tack_cfg.svh ====
`ifndef TACK_CFG_SVH
`define TACK_CFG_SVH

//////////////////////////////
// ROM setup delays
//////////////////////////////

// Setup clocks before a ROM or autovector ack, normal case
`define ROM_FAST_WAIT 3'd1

// Setup clocks with the ROM delay strap set
// About 100 ns at 80 MHz
`define ROM_SLOW_WAIT 3'd5

//////////////////////////////
// Bus watchdog
//////////////////////////////

// Clocks before an unclaimed cycle is ended by the bridge
// Longer than the slowest peripheral cycle
`define TIMEOUT_WAIT 8'd249

//////////////////////////////
// Ack pulse shape
//////////////////////////////

// Clocks the ack line is driven low
`define TACK_LOW_CYCLES 2'd2

`endif

// ==== design/tackPkg.sv ====
package tackPkg;

    //////////////////////////////
    // Bus cycle inputs
    //////////////////////////////

    // Pin levels seen at the start of a CPU bus cycle
    typedef struct packed {
        // TS asserted, already inverted from the pin
        logic tsActive;
        // Phase level of the 40 MHz CPU clock
        logic clk40High;
        logic romSel;
        logic autoVector;
        // Long ROM setup strap
        logic romDelay;
        logic ciaSel;
        // Chipset space, ended by the chipset itself
        logic agnusSpace;
    } busCycleT;

    // One-clock ack requests into the sequencer
    typedef struct packed {
        logic romAck;
        logic ciaAck;
        logic timeoutAck;
    } ackSrcT;

    //////////////////////////////
    // State encodings
    //////////////////////////////

    // Peripheral cycle tracking
    typedef enum logic [1:0] {
        CIA_IDLE      = 2'b00,
        CIA_WAIT_HIGH = 2'b01,
        CIA_WAIT_LOW  = 2'b10,
        CIA_DONE      = 2'b11
    } ciaStateT;

    // Ack pulse shaping
    typedef enum logic [1:0] {
        SEQ_IDLE       = 2'b00,
        SEQ_DRIVE_LOW  = 2'b01,
        SEQ_DRIVE_HIGH = 2'b10
    } seqStateT;

endpackage

// ==== design/romAckTimer.sv ====
`timescale 1ns/1ps
`include "tack_cfg.svh"

module romAckTimer (
    input  logic              CLK80,
    input  logic              DELAYED_TACK_RST,
    input  tackPkg::busCycleT cycle,
    output logic              romAck
);

    //////////////////////////////
    // Start detect
    //////////////////////////////

    // Clocks since the accepted start, zero when idle
    logic [2:0] waitCnt;
    // Setup length picked by the strap
    logic [2:0] termCnt;
    logic       romStart;

    // TS seen on the high CPU clock phase, ROM or autovector target
    assign romStart = cycle.tsActive && cycle.clk40High
                      && (cycle.romSel || cycle.autoVector);

    // Long setup for slow ROM parts
    assign termCnt = cycle.romDelay ? `ROM_SLOW_WAIT : `ROM_FAST_WAIT;

    //////////////////////////////
    // Setup counter
    //////////////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            waitCnt <= 3'd0;
            romAck  <= 1'b0;
        end else begin
            // Ack is a single clock request
            romAck <= 1'b0;
            if (waitCnt == 3'd0) begin
                // Idle, arm on a new ROM cycle
                if (romStart) begin
                    waitCnt <= 3'd1;
                end
            end else if (waitCnt > termCnt) begin
                // Setup clocks fully elapsed
                romAck  <= 1'b1;
                waitCnt <= 3'd0;
            end else begin
                waitCnt <= waitCnt + 3'd1;
            end
        end
    end

    // Fast path acks 2 clocks after the start edge
    // slow path 6 clocks after

endmodule

// ==== design/ciaAckSync.sv ====
`timescale 1ns/1ps

module ciaAckSync (
    input  logic              CLK80,
    input  logic              DELAYED_TACK_RST,
    input  logic              ciaClk,
    input  tackPkg::busCycleT cycle,
    output logic              ciaAck
);

    import tackPkg::*;

    //////////////////////////////
    // Synchronizers
    //////////////////////////////

    // Bit 0 is the first stage, bit 1 the second
    logic [1:0] selSync;
    logic [1:0] clkSync;
    ciaStateT   ciaState;

    // Peripheral clock and select are asynchronous to CLK80
    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            selSync <= 2'b00;
            clkSync <= 2'b00;
        end else begin
            selSync <= {selSync[0], cycle.ciaSel};
            clkSync <= {clkSync[0], ciaClk};
        end
    end

    //////////////////////////////
    // Termination FSM
    //////////////////////////////

    // Cycle ends at or just after the peripheral clock falls
    // while select is held
    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            ciaState <= CIA_IDLE;
            ciaAck   <= 1'b0;
        end else begin
            ciaAck <= 1'b0;
            case (ciaState)
                CIA_IDLE: begin
                    // Select stable in both stages
                    if (selSync == 2'b11) begin
                        ciaState <= CIA_WAIT_HIGH;
                    end
                end
                CIA_WAIT_HIGH: begin
                    // Need a full high phase first
                    if (clkSync == 2'b11) begin
                        ciaState <= CIA_WAIT_LOW;
                    end
                end
                CIA_WAIT_LOW: begin
                    // Falling edge seen, end on low CPU phase
                    if (clkSync == 2'b00 && !cycle.clk40High) begin
                        ciaAck   <= 1'b1;
                        ciaState <= CIA_DONE;
                    end
                end
                CIA_DONE: begin
                    // Hold off until select goes away
                    if (selSync == 2'b00) begin
                        ciaState <= CIA_IDLE;
                    end
                end
                default: begin
                    ciaState <= CIA_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== design/busTimeoutWatchdog.sv ====
`timescale 1ns/1ps
`include "tack_cfg.svh"

module busTimeoutWatchdog (
    input  logic              CLK80,
    input  logic              DELAYED_TACK_RST,
    input  tackPkg::busCycleT cycle,
    input  logic              busTackN,
    output logic              timeoutAck
);

    //////////////////////////////
    // Start and clear
    //////////////////////////////

    // Clocks since the accepted start, zero when idle
    logic [7:0] waitCnt;
    logic       tackSeen;
    logic       cycleStart;
    logic       clearCnt;

    // Ack on the bus from any device, this bridge included
    assign tackSeen = !busTackN;

    // Any target, decoded or not
    assign cycleStart = cycle.tsActive && cycle.clk40High;

    // Chipset space cycles are ended by the chipset
    assign clearCnt = tackSeen || cycle.agnusSpace;

    //////////////////////////////
    // Timeout counter
    //////////////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            waitCnt    <= 8'd0;
            timeoutAck <= 1'b0;
        end else begin
            timeoutAck <= 1'b0;
            if (clearCnt) begin
                // Cycle claimed, stop watching
                waitCnt <= 8'd0;
            end else if (waitCnt == 8'd0) begin
                if (cycleStart) begin
                    waitCnt <= 8'd1;
                end
            end else if (waitCnt > `TIMEOUT_WAIT) begin
                // Nobody answered, end it here
                timeoutAck <= 1'b1;
                waitCnt    <= 8'd0;
            end else begin
                waitCnt <= waitCnt + 8'd1;
            end
        end
    end

    // Fires 250 clocks after the start edge
    // well past the slowest peripheral cycle

endmodule

// ==== design/tackSequencer.sv ====
`timescale 1ns/1ps
`include "tack_cfg.svh"

module tackSequencer (
    input  logic           CLK80,
    input  logic           DELAYED_TACK_RST,
    input  tackPkg::ackSrcT ackReq,
    output logic           tackDrive,
    output logic           tackEn
);

    import tackPkg::*;

    //////////////////////////////
    // Request merge
    //////////////////////////////

    seqStateT   seqState;
    // Clocks spent driving low, loaded on entry
    logic [1:0] lowCnt;
    logic       anyReq;

    // Sources never overlap within one bus cycle
    assign anyReq = ackReq.romAck || ackReq.ciaAck || ackReq.timeoutAck;

    //////////////////////////////
    // Pulse shaping FSM
    //////////////////////////////

    // Low for the set count, one clock high, then tristate
    // Driving high first gives a clean negation on the bus
    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            seqState  <= SEQ_IDLE;
            lowCnt    <= 2'd0;
            tackEn    <= 1'b0;
            tackDrive <= 1'b1;
        end else begin
            case (seqState)
                SEQ_IDLE: begin
                    // Line released while idle
                    tackEn    <= 1'b0;
                    tackDrive <= 1'b1;
                    if (anyReq) begin
                        seqState  <= SEQ_DRIVE_LOW;
                        lowCnt    <= 2'd1;
                        tackEn    <= 1'b1;
                        tackDrive <= 1'b0;
                    end
                end
                SEQ_DRIVE_LOW: begin
                    // Requests here are dropped
                    if (lowCnt == `TACK_LOW_CYCLES) begin
                        seqState  <= SEQ_DRIVE_HIGH;
                        tackDrive <= 1'b1;
                    end else begin
                        lowCnt <= lowCnt + 2'd1;
                    end
                end
                SEQ_DRIVE_HIGH: begin
                    // One clock high, then let go
                    seqState <= SEQ_IDLE;
                    tackEn   <= 1'b0;
                end
                default: begin
                    seqState  <= SEQ_IDLE;
                    tackEn    <= 1'b0;
                    tackDrive <= 1'b1;
                end
            endcase
        end
    end

    // Line goes low one clock after a request
    // and is released three clocks later

endmodule

// ==== design/transferAckUnit.sv ====
`timescale 1ns/1ps

module transferAckUnit (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic tsN,
    input  logic clk40,
    input  logic romSel,
    input  logic autoVector,
    input  logic romDelay,
    input  logic ciaSel,
    input  logic ciaClk,
    input  logic agnusSpace,
    input  logic busTackN,
    output logic tackDrive,
    output logic tackEn
);

    import tackPkg::*;

    //////////////////////////////
    // Pin packing
    //////////////////////////////

    busCycleT cycle;
    ackSrcT   ackReq;
    logic     romAck;
    logic     ciaAck;
    logic     timeoutAck;

    // TS is active low on the pin
    assign cycle = '{
        tsActive:   !tsN,
        clk40High:  clk40,
        romSel:     romSel,
        autoVector: autoVector,
        romDelay:   romDelay,
        ciaSel:     ciaSel,
        agnusSpace: agnusSpace
    };

    // Ack requests from the three datapath blocks
    assign ackReq = '{romAck: romAck, ciaAck: ciaAck, timeoutAck: timeoutAck};

    //////////////////////////////
    // Ack sources
    //////////////////////////////

    romAckTimer u_romAckTimer (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .cycle            (cycle),
        .romAck           (romAck)
    );

    ciaAckSync u_ciaAckSync (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .ciaClk           (ciaClk),
        .cycle            (cycle),
        .ciaAck           (ciaAck)
    );

    // Sees the resolved bus line, not just our own drive
    busTimeoutWatchdog u_busTimeoutWatchdog (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .cycle            (cycle),
        .busTackN         (busTackN),
        .timeoutAck       (timeoutAck)
    );

    //////////////////////////////
    // Ack line driver
    //////////////////////////////

    tackSequencer u_tackSequencer (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .ackReq           (ackReq),
        .tackDrive        (tackDrive),
        .tackEn           (tackEn)
    );

endmodule

// ==== tb/tbTransferAck.sv ====
`timescale 1ns/1ps

module tbTransferAck;

    localparam int DRIVE_DELAY = 2;
    // Peripheral clock half period in CLK80 cycles
    localparam int CIA_HALF = 6;

    logic CLK80;
    logic DELAYED_TACK_RST;
    logic tsN, clk40, romSel, autoVector, romDelay;
    logic ciaSel, ciaClk, agnusSpace, extLevel;
    logic busTackN, tackDrive, tackEn, accept;
    logic expectTimeout, quietWindow;

    logic [7:0] lfsrState;
    string      testName;
    int         ciaSkew, tickCount, failsAtStart;
    int         assertFails, waitFails, testsRun, testsFailed;

    // Peripheral cycle history
    bit         started;
    logic       tackEnQ, sawHigh, sawFall;
    logic [7:0] selHeld;
    logic [3:0] ciaAcks;

    // Open drain style line pulled high unless someone drives it
    assign busTackN = tackEn ? tackDrive : extLevel;
    // Cycle start as the DUT accepts it
    assign accept = !tsN && clk40;

    transferAckUnit u_transferAckUnit (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .tsN              (tsN),
        .clk40            (clk40),
        .romSel           (romSel),
        .autoVector       (autoVector),
        .romDelay         (romDelay),
        .ciaSel           (ciaSel),
        .ciaClk           (ciaClk),
        .agnusSpace       (agnusSpace),
        .busTackN         (busTackN),
        .tackDrive        (tackDrive),
        .tackEn           (tackEn)
    );

    //////////////////////////////
    // Clocks
    //////////////////////////////

    initial begin
        CLK80 = 1'b0;
        forever #20 CLK80 = !CLK80;
    end

    // CPU clock phase and slow peripheral clock move just after the edge
    initial begin
        clk40 = 1'b0;
        ciaClk = 1'b0;
        tickCount = 0;
        forever begin
            @(posedge CLK80);
            #DRIVE_DELAY;
            clk40 = !clk40;
            tickCount++;
            ciaClk = ((tickCount + ciaSkew) / CIA_HALF) % 2 == 1;
        end
    end

    always @(posedge CLK80) begin
        tackEnQ <= tackEn;
        if (!tsN || ciaSel) begin
            started <= 1'b1;
        end
        if (!ciaSel) begin
            selHeld <= 8'd0;
            ciaAcks <= 4'd0;
            sawHigh <= 1'b0;
            sawFall <= 1'b0;
        end else begin
            selHeld <= selHeld + 8'd1;
            if (ciaClk) begin
                sawHigh <= 1'b1;
            end else if (sawHigh) begin
                sawFall <= 1'b1;
            end
            if (tackEn && !tackEnQ) begin
                ciaAcks <= ciaAcks + 4'd1;
            end
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    resetQuiet: assert property (@(posedge CLK80) !started |-> !tackEn)
        else begin
            assertFails++;
            $display("ERR %s: expected tackEn 0, actual %b", testName, $sampled(tackEn));
        end
    // Set on edge 3 after the start and so sampled high on edge 4
    romFast: assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        accept && (romSel || autoVector) && !romDelay |-> ##4 $rose(tackEn))
        else begin
            assertFails++;
            $display("ERR %s: expected tackEn rise at +3, actual %b",
                     testName, $sampled(tackEn));
        end
    romSlow: assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        accept && (romSel || autoVector) && romDelay |-> ##8 $rose(tackEn))
        else begin
            assertFails++;
            $display("ERR %s: expected tackEn rise at +7, actual %b",
                     testName, $sampled(tackEn));
        end
    timeoutRise: assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        accept && expectTimeout |-> ##252 $rose(tackEn))
        else begin
            assertFails++;
            $display("ERR %s: expected tackEn rise at +251, actual %b",
                     testName, $sampled(tackEn));
        end
    // Two clocks low then one high before release
    pulseShape: assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        $rose(tackEn) |-> !tackDrive ##1 (tackEn && !tackDrive)
        ##1 (tackEn && tackDrive) ##1 !tackEn)
        else begin
            assertFails++;
            $display("ERR %s: expected drive 0,0,1 then release, actual en %b drive %b",
                     testName, $sampled(tackEn), $sampled(tackDrive));
        end
    ciaOrder: assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        ciaSel && $rose(tackEn) |-> sawFall && selHeld >= 8'd2)
        else begin
            assertFails++;
            $display("ERR %s: expected fall seen 1, actual %b after %0d clocks",
                     testName, $sampled(sawFall), $sampled(selHeld));
        end
    ciaOnce: assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        $fell(ciaSel) |-> ciaAcks == 4'd1)
        else begin
            assertFails++;
            $display("ERR %s: expected 1 ack per select, actual %0d",
                     testName, $sampled(ciaAcks));
        end
    quiet: assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        quietWindow |-> !tackEn)
        else begin
            assertFails++;
            $display("ERR %s: expected tackEn 0, actual %b", testName, $sampled(tackEn));
        end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsrNext(input logic [7:0] s);
        logic fb;
        fb = s[7] ^ s[5] ^ s[4] ^ s[3];
        return {s[6:0], fb};
    endfunction

    task automatic drawBits(input int n, output int val);
        int i;
        val = 0;
        for (i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            val = (val << 1) | int'(lfsrState[0]);
        end
    endtask

    task automatic idleGap;
        int gap;
        drawBits(3, gap);
        repeat (gap + 2) @(posedge CLK80);
        #DRIVE_DELAY;
    endtask

    // TS low for one edge on the high CPU clock phase
    task automatic startCycle;
        int guard;
        guard = 0;
        @(posedge CLK80);
        // clk40 flips at the drive point so low now means high at the next edge
        while (clk40 !== 1'b0 && guard < 4) begin
            @(posedge CLK80);
            guard++;
        end
        if (clk40 !== 1'b0) begin
            waitFails++;
            $display("%s: CPU clock phase never came round for a cycle start", testName);
        end
        #DRIVE_DELAY;
        tsN = 1'b0;
        @(posedge CLK80);
        #DRIVE_DELAY;
        tsN = 1'b1;
    endtask

    // One whole ack pulse from rise to release
    task automatic waitAck(input int limit);
        int n;
        n = 0;
        while (tackEn !== 1'b1 && n < limit) begin
            @(posedge CLK80);
            n++;
        end
        if (tackEn !== 1'b1) begin
            waitFails++;
            $display("%s: no acknowledge within %0d clocks", testName, limit);
        end else begin
            n = 0;
            while (tackEn !== 1'b0 && n < 8) begin
                @(posedge CLK80);
                n++;
            end
            if (tackEn !== 1'b0) begin
                waitFails++;
                $display("%s: acknowledge line never released", testName);
            end
        end
        #DRIVE_DELAY;
    endtask

    // Another device pulls the line for two clocks at pullAt
    task automatic quietFor(input int n, input int pullAt);
        int i;
        quietWindow = 1'b1;
        for (i = 0; i < n; i++) begin
            extLevel = (pullAt >= 0 && i >= pullAt && i < pullAt + 2) ? 1'b0 : 1'b1;
            @(posedge CLK80);
            #DRIVE_DELAY;
        end
        extLevel = 1'b1;
        quietWindow = 1'b0;
    endtask

    task automatic beginTest(input string name);
        testName = name;
        failsAtStart = assertFails + waitFails;
    endtask

    task automatic endTest;
        int fails;
        fails = assertFails + waitFails - failsAtStart;
        testsRun++;
        if (fails == 0) begin
            $display("test %s: passed", testName);
        end else begin
            testsFailed++;
            $display("test %s: %0d check(s) failed", testName, fails);
        end
    endtask

    task automatic romCycle(input string name, input logic sel, input logic av,
                            input logic dly);
        beginTest(name);
        romSel = sel;
        autoVector = av;
        romDelay = dly;
        startCycle();
        waitAck(12);
        romSel = 1'b0;
        autoVector = 1'b0;
        romDelay = 1'b0;
        endTest();
        idleGap();
    endtask

    task automatic ciaCycle(input string name);
        int skew;
        beginTest(name);
        drawBits(4, skew);
        ciaSkew = skew;
        ciaSel = 1'b1;
        startCycle();
        waitAck(80);
        // Several more peripheral periods with select still held
        repeat (40) @(posedge CLK80);
        #DRIVE_DELAY;
        ciaSel = 1'b0;
        repeat (3) @(posedge CLK80);
        #DRIVE_DELAY;
        endTest();
        idleGap();
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        DELAYED_TACK_RST = 1'b1;
        tsN = 1'b1;
        romSel = 1'b0;
        autoVector = 1'b0;
        romDelay = 1'b0;
        ciaSel = 1'b0;
        agnusSpace = 1'b0;
        extLevel = 1'b1;
        expectTimeout = 1'b0;
        quietWindow = 1'b0;
        ciaSkew = 0;
        lfsrState = 8'd93;
        beginTest("reset");
        repeat (4) @(posedge CLK80);
        #DRIVE_DELAY;
        DELAYED_TACK_RST = 1'b0;
        repeat (10) @(posedge CLK80);
        #DRIVE_DELAY;
        endTest();
        romCycle("romFast", 1'b1, 1'b0, 1'b0);
        romCycle("romSlow", 1'b1, 1'b0, 1'b1);
        romCycle("autoVectorFast", 1'b0, 1'b1, 1'b0);
        romCycle("autoVectorSlow", 1'b0, 1'b1, 1'b1);
        ciaCycle("ciaFirst");
        ciaCycle("ciaSecond");
        beginTest("timeout");
        expectTimeout = 1'b1;
        startCycle();
        expectTimeout = 1'b0;
        waitAck(270);
        endTest();
        beginTest("agnusClear");
        agnusSpace = 1'b1;
        startCycle();
        quietFor(300, -1);
        agnusSpace = 1'b0;
        endTest();
        beginTest("externalAckClear");
        startCycle();
        quietFor(300, 100);
        endTest();
        beginTest("romNoTimeout");
        romSel = 1'b1;
        startCycle();
        waitAck(12);
        romSel = 1'b0;
        quietFor(300, -1);
        endTest();
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors, %0d wait errors",
                 testsRun, testsRun - testsFailed, testsFailed, assertFails, waitFails);
        if (testsFailed == 0 && assertFails == 0 && waitFails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== transferAckUnit.f ====
+incdir+design
design/tackPkg.sv
design/romAckTimer.sv
design/ciaAckSync.sv
design/busTimeoutWatchdog.sv
design/tackSequencer.sv
design/transferAckUnit.sv
tb/tbTransferAck.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tbTransferAck
FILELIST  = transferAckUnit.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
PASS_TEXT = Simulation completed successfully

SOURCES   = $(shell grep -v '^+' $(FILELIST))
HEADERS   = design/tack_cfg.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
